// File: logic/rv_pkg.sv
// RV32I integer core definitions
// data and register types, opcode and ALU encodings, the stage structs
// and the immediate decoder shared by the three pipeline stages
package rv_pkg;

    // one architectural data word, used for register values, operands and results
    typedef logic [31:0] xlen_t;

    // register number as it appears in the rd, rs1 and rs2 fields
    typedef logic [4:0] reg_idx_t;

    // major opcodes this core accepts, low two bits are always 11 for 32-bit words
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    // funct3 codes, shared by the register and immediate forms
    localparam logic [2:0] F3_ADDSUB = 3'b000;
    localparam logic [2:0] F3_SLL    = 3'b001;
    localparam logic [2:0] F3_SLT    = 3'b010;
    localparam logic [2:0] F3_SLTU   = 3'b011;
    localparam logic [2:0] F3_XOR    = 3'b100;
    localparam logic [2:0] F3_SR     = 3'b101;
    localparam logic [2:0] F3_OR     = 3'b110;
    localparam logic [2:0] F3_AND    = 3'b111;

    // funct7 values, the alternate one selects SUB and SRA
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // operation chosen by decode and carried out in execute
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI,
        ALU_ILLEGAL
    } alu_op_e;

    // decode-to-execute payload, operands are already forwarded
    typedef struct packed {
        logic     valid;
        alu_op_e  op;
        reg_idx_t rd;
        logic     we;
        xlen_t    rs1_value;
        xlen_t    rs2_value;
        xlen_t    imm;
        logic     use_imm;
    } decoded_t;

    // one finished instruction, from the execute result up to retirement
    typedef struct packed {
        logic     valid;
        logic     illegal;
        logic     we;
        reg_idx_t rd;
        xlen_t    value;
    } retire_t;

    // LUI takes the upper twenty bits as they are, every other form here is I-type
    function automatic xlen_t decode_immediate(logic [31:0] instr);
        if (instr[6:0] == OPC_LUI) begin
            return {instr[31:12], 12'b0};
        end
        return {{20{instr[31]}}, instr[31:20]};
    endfunction

endpackage

// File: logic/rv_decode.sv
// RV32I decode stage
// holds the instruction register, turns the word into an ALU operation,
// reads both sources from the register file or the later stages and
// loads the decode-to-execute register
`timescale 1ns/1ns

module rv_decode #(
    parameter int num_regs = 32
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             instr_valid,
    input  logic [31:0]      instr_word,
    input  rv_pkg::retire_t  ex_bypass,
    input  rv_pkg::retire_t  ex_result,
    input  rv_pkg::retire_t  retire,
    output rv_pkg::decoded_t decoded
);
    import rv_pkg::*;

    // index bits that actually address the register file
    localparam int reg_bits = $clog2(num_regs);

    logic        ir_valid;
    logic [31:0] ir_word;
    xlen_t       regs [num_regs];
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic        base_ok;
    logic        rs2_used;
    logic        range_ok;
    alu_op_e     op;
    decoded_t    de_next;

    // a stage only forwards a value that it will really write
    function automatic logic hits(retire_t src, reg_idx_t idx);
        return src.valid && src.we && src.rd == idx;
    endfunction

    // newest producer first, since it overwrites what the older ones wrote
    function automatic xlen_t read_operand(reg_idx_t idx);
        if (hits(ex_bypass, idx)) return ex_bypass.value;
        if (hits(ex_result, idx)) return ex_result.value;
        if (hits(retire, idx)) return retire.value;
        // x0 reads as zero and is never stored
        if (idx == '0 || int'(idx) >= num_regs) return '0;
        return regs[idx[reg_bits-1:0]];
    endfunction

    // the word arrives with no handshake, so every valid cycle loads it
    always_ff @(posedge clock) begin
        if (reset) begin
            ir_valid <= 1'b0;
        end else begin
            ir_valid <= instr_valid;
        end
        if (instr_valid) begin
            ir_word <= instr_word;
        end
    end

    always_comb begin
        opcode = ir_word[6:0];
        rd     = ir_word[11:7];
        funct3 = ir_word[14:12];
        rs1    = ir_word[19:15];
        rs2    = ir_word[24:20];
        funct7 = ir_word[31:25];
        // in the immediate form the funct7 field is part of the immediate
        base_ok  = opcode == OPC_OP_IMM || funct7 == F7_BASE;
        rs2_used = opcode == OPC_OP;

        op = ALU_ILLEGAL;
        if (opcode == OPC_LUI) begin
            op = ALU_LUI;
        end else if (opcode == OPC_OP || opcode == OPC_OP_IMM) begin
            case (funct3)
                F3_ADDSUB: begin
                    // there is no SUBI, so funct7 only matters in the register form
                    if (base_ok) op = ALU_ADD;
                    else if (funct7 == F7_ALT) op = ALU_SUB;
                end
                F3_SLT:  if (base_ok) op = ALU_SLT;
                F3_SLTU: if (base_ok) op = ALU_SLTU;
                F3_XOR:  if (base_ok) op = ALU_XOR;
                F3_OR:   if (base_ok) op = ALU_OR;
                F3_AND:  if (base_ok) op = ALU_AND;
                // shift immediates keep funct7 as a real field
                F3_SLL:  if (funct7 == F7_BASE) op = ALU_SLL;
                F3_SR: begin
                    if (funct7 == F7_BASE) op = ALU_SRL;
                    else if (funct7 == F7_ALT) op = ALU_SRA;
                end
                default: op = ALU_ILLEGAL;
            endcase
        end

        // a reduced register file rejects any register it does not have
        range_ok = int'(rd) < num_regs
            && (opcode == OPC_LUI || int'(rs1) < num_regs)
            && (!rs2_used || int'(rs2) < num_regs);
        if (!range_ok) op = ALU_ILLEGAL;

        de_next.valid     = ir_valid;
        de_next.op        = op;
        de_next.rd        = rd;
        de_next.we        = op != ALU_ILLEGAL && rd != '0;
        de_next.rs1_value = read_operand(rs1);
        de_next.rs2_value = read_operand(rs2);
        de_next.imm       = decode_immediate(ir_word);
        de_next.use_imm   = opcode != OPC_OP;
    end

    // the retire port is the only writer of the register file
    always_ff @(posedge clock) begin
        if (retire.valid && retire.we) begin
            regs[retire.rd[reg_bits-1:0]] <= retire.value;
        end
    end

    // only the valid bit needs clearing, the payload follows it
    always_ff @(posedge clock) begin
        decoded <= de_next;
        if (reset) begin
            decoded.valid <= 1'b0;
        end
    end

    // the write enable built here must keep x0 out of the file two stages later
    a_no_x0_write: assert property (@(posedge clock) disable iff (reset)
        retire.valid && retire.we |-> retire.rd != '0);

endmodule

// File: logic/rv_execute.sv
// RV32I execute stage
// runs the ALU on the forwarded operands, offers the result straight back
// to decode and registers it for the result stage
`timescale 1ns/1ns

module rv_execute (
    input  logic             clock,
    input  logic             reset,
    input  rv_pkg::decoded_t decoded,
    output rv_pkg::retire_t  ex_bypass,
    output rv_pkg::retire_t  ex_result
);
    import rv_pkg::*;

    xlen_t      operand_a;
    xlen_t      operand_b;
    logic [4:0] shamt;
    xlen_t      alu_out;

    always_comb begin
        operand_a = decoded.rs1_value;
        // SUB only decodes from the register form, so it always sees rs2 here
        operand_b = decoded.use_imm ? decoded.imm : decoded.rs2_value;
        // shifts use only the low five bits of rs2 or of the immediate
        shamt = operand_b[4:0];

        case (decoded.op)
            ALU_ADD:  alu_out = operand_a + operand_b;
            ALU_SUB:  alu_out = operand_a - operand_b;
            ALU_SLT:  alu_out = {31'b0, $signed(operand_a) < $signed(operand_b)};
            ALU_SLTU: alu_out = {31'b0, operand_a < operand_b};
            ALU_XOR:  alu_out = operand_a ^ operand_b;
            ALU_OR:   alu_out = operand_a | operand_b;
            ALU_AND:  alu_out = operand_a & operand_b;
            ALU_SLL:  alu_out = operand_a << shamt;
            ALU_SRL:  alu_out = operand_a >> shamt;
            ALU_SRA:  alu_out = xlen_t'($signed(operand_a) >>> shamt);
            ALU_LUI:  alu_out = decoded.imm;
            // an illegal word reports zero and writes nothing
            default:  alu_out = '0;
        endcase

        // this is the newest forwarding source seen by decode
        ex_bypass.valid   = decoded.valid;
        ex_bypass.illegal = decoded.op == ALU_ILLEGAL;
        ex_bypass.we      = decoded.we;
        ex_bypass.rd      = decoded.rd;
        ex_bypass.value   = alu_out;
    end

    // execute-to-result register, the value is forwarded from here as well
    always_ff @(posedge clock) begin
        ex_result <= ex_bypass;
        if (reset) begin
            ex_result.valid <= 1'b0;
        end
    end

    // decode must never hand an illegal operation a write enable
    a_illegal_no_we: assert property (@(posedge clock) disable iff (reset)
        decoded.valid && decoded.op == ALU_ILLEGAL |-> !decoded.we);

endmodule

// File: logic/rv_result.sv
// RV32I result stage
// last pipeline register whose output both writes the register file and
// reports the retired instruction
`timescale 1ns/1ns

module rv_result (
    input  logic            clock,
    input  logic            reset,
    input  rv_pkg::retire_t ex_result,
    output rv_pkg::retire_t retire
);

    // one register feeds the register file write and the retire port,
    // so what is observed outside is exactly what was written
    always_ff @(posedge clock) begin
        retire <= ex_result;
        // after reset nothing retires until a real instruction arrives
        if (reset) begin
            retire.valid <= 1'b0;
        end
    end

    // an illegal word must reach retirement with its write suppressed
    a_illegal_retire: assert property (@(posedge clock) disable iff (reset)
        retire.valid && retire.illegal |-> !retire.we);

endmodule

// File: logic/rv_core.sv
// RV32I three-stage integer core
// decode, execute and result stages in a row, one instruction word accepted
// per cycle and every instruction reported on the retire port three cycles later
`timescale 1ns/1ns

module rv_core #(
    parameter int num_regs = 32
) (
    input  logic            clock,
    input  logic            reset,
    input  logic            instr_valid,
    input  logic [31:0]     instr_word,
    output rv_pkg::retire_t retire
);
    import rv_pkg::*;

    // decode-to-execute register
    decoded_t decoded;
    // combinational execute result, newest forwarding source
    retire_t  ex_bypass;
    // execute-to-result register
    retire_t  ex_result;

    // the retire port doubles as the register file write and oldest bypass
    rv_decode #(
        .num_regs    (num_regs)
    ) i_decode (
        .clock       (clock),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr_word  (instr_word),
        .ex_bypass   (ex_bypass),
        .ex_result   (ex_result),
        .retire      (retire),
        .decoded     (decoded)
    );

    rv_execute i_execute (
        .clock       (clock),
        .reset       (reset),
        .decoded     (decoded),
        .ex_bypass   (ex_bypass),
        .ex_result   (ex_result)
    );

    rv_result i_result (
        .clock       (clock),
        .reset       (reset),
        .ex_result   (ex_result),
        .retire      (retire)
    );

endmodule

// File: bench/rv_core_tb.sv
// testbench for the RV32I three-stage core
// directed tests run against a register model, and a monitor checks every
// retired instruction for its value and for the three-cycle latency
`timescale 1ns/1ns

module rv_core_tb;
    import rv_pkg::*;

    logic        clock = 1'b0;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr_word;
    retire_t     retire;

    // architectural state as the instruction stream defines it
    xlen_t   model [32];
    retire_t exp_q [$];
    int      accept_q [$];
    retire_t head;
    int      head_edge;
    int      edge_count = 0;
    int      value_errors = 0;
    int      timing_errors = 0;
    int      other_errors = 0;
    string   current_test = "reset";

    // funct7 and funct3 of ADD, SUB, SLT, SLTU, XOR, OR, AND, SLL, SRL and SRA
    localparam logic [9:0] r_ops [10] = '{
        {7'h00, 3'd0}, {7'h20, 3'd0}, {7'h00, 3'd2}, {7'h00, 3'd3}, {7'h00, 3'd4},
        {7'h00, 3'd6}, {7'h00, 3'd7}, {7'h00, 3'd1}, {7'h00, 3'd5}, {7'h20, 3'd5}
    };

    rv_core i_dut (
        .clock       (clock),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr_word  (instr_word),
        .retire      (retire)
    );

    always #20 clock = ~clock;

    // an accepted word retires three counted edges after the edge that took it
    always @(posedge clock) edge_count <= edge_count + 1;

    function automatic logic [31:0] encode_r(logic [6:0] f7, logic [2:0] f3,
                                             int rd, int rs1, int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'h33};
    endfunction

    function automatic logic [31:0] encode_i(int imm, logic [2:0] f3, int rd, int rs1);
        return {12'(imm), 5'(rs1), f3, 5'(rd), 7'h13};
    endfunction

    function automatic logic [31:0] encode_lui(logic [19:0] upper, int rd);
        return {upper, 5'(rd), 7'h37};
    endfunction

    // reference result of one word as the RV32I rules give it against the model
    function automatic retire_t predict(logic [31:0] w);
        logic [6:0] opc;
        logic [6:0] f7;
        logic       plain;
        logic       ok;
        xlen_t      a;
        xlen_t      b;
        xlen_t      res;
        retire_t    r;
        opc = w[6:0];
        f7 = w[31:25];
        a = model[w[19:15]];
        // the immediate forms compare and shift against the sign-extended imm
        b = (opc == 7'h33) ? model[w[24:20]] : {{20{w[31]}}, w[31:20]};
        // upper immediate bits are free except in the shift forms
        plain = opc == 7'h13 || f7 == 7'h00;
        ok = 1'b1;
        res = '0;
        if (opc == 7'h37) begin
            res = {w[31:12], 12'b0};
        end else if (opc == 7'h33 || opc == 7'h13) begin
            case (w[14:12])
                3'd0: begin
                    if (plain) res = a + b;
                    else if (opc == 7'h33 && f7 == 7'h20) res = a - b;
                    else ok = 1'b0;
                end
                3'd2: if (plain) res = xlen_t'($signed(a) < $signed(b)); else ok = 1'b0;
                3'd3: if (plain) res = xlen_t'(a < b); else ok = 1'b0;
                3'd4: if (plain) res = a ^ b; else ok = 1'b0;
                3'd6: if (plain) res = a | b; else ok = 1'b0;
                3'd7: if (plain) res = a & b; else ok = 1'b0;
                3'd1: if (f7 == 7'h00) res = a << b[4:0]; else ok = 1'b0;
                default: begin
                    if (f7 == 7'h00) res = a >> b[4:0];
                    // arithmetic shift fills the vacated top bits with the sign
                    else if (f7 == 7'h20) res = (a >> b[4:0]) | (a[31] ? ~('1 >> b[4:0]) : '0);
                    else ok = 1'b0;
                end
            endcase
        end else begin
            ok = 1'b0;
        end
        r.valid = 1'b1;
        r.illegal = !ok;
        r.we = ok && w[11:7] != 5'd0;
        r.rd = w[11:7];
        r.value = ok ? res : '0;
        return r;
    endfunction

    function automatic logic [31:0] random_legal();
        int k;
        int imm;
        k = $urandom_range(9);
        case ($urandom_range(2))
            0: return encode_r(r_ops[k][9:3], r_ops[k][2:0], $urandom_range(31),
                               $urandom_range(31), $urandom_range(31));
            1: return encode_lui(20'($urandom), $urandom_range(31));
            default: begin
                // SUB has no immediate form and turns into ADDI here
                if (k == 1) k = 0;
                imm = $urandom_range(4095);
                // shifts keep funct7 in the upper immediate bits
                if (r_ops[k][2:0] == 3'd1 || r_ops[k][2:0] == 3'd5) begin
                    imm = int'({r_ops[k][9:3], 5'(imm)});
                end
                return encode_i(imm, r_ops[k][2:0], $urandom_range(31), $urandom_range(31));
            end
        endcase
    endfunction

    // the model moves on at issue time in program order
    task automatic issue(logic [31:0] w);
        retire_t r;
        r = predict(w);
        if (r.we) model[r.rd] = r.value;
        @(posedge clock);
        #1;
        instr_valid = 1'b1;
        instr_word = w;
        exp_q.push_back(r);
        accept_q.push_back(edge_count + 1);
    endtask

    task automatic idle(int cycles);
        repeat (cycles) begin
            @(posedge clock);
            #1;
            instr_valid = 1'b0;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        idle(1);
        while (exp_q.size() != 0 && waited < 50) begin
            @(posedge clock);
            waited++;
        end
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("%s: %0d instructions never retired", current_test, exp_q.size());
            exp_q.delete();
            accept_q.delete();
        end
    endtask

    // every register gets a known value because the register file is not cleared
    task automatic load_registers();
        current_test = "load registers";
        for (int i = 1; i < 32; i++) begin
            issue(encode_lui(20'($urandom), i));
            issue(encode_i($urandom_range(4095), 3'd0, i, i));
        end
        drain();
    endtask

    task automatic immediate_forms();
        current_test = "immediate forms";
        issue(encode_i(-5, 3'd0, 1, 2));
        issue(encode_i(-7, 3'd0, 3, 0));
        issue(encode_i(-3, 3'd2, 4, 3));
        issue(encode_i(-9, 3'd2, 5, 3));
        issue(encode_i(5, 3'd3, 6, 3));
        issue(encode_i(-1, 3'd3, 7, 3));
        issue(encode_i(12'h5a5, 3'd4, 8, 3));
        issue(encode_i(12'h0f0, 3'd6, 9, 1));
        issue(encode_i(12'h8ff, 3'd7, 10, 1));
        issue(encode_i(13, 3'd1, 11, 3));
        issue(encode_i(7, 3'd5, 12, 3));
        issue(encode_i(12'h400 | 7, 3'd5, 13, 3));
        issue(encode_lui(20'hdead5, 14));
        drain();
    endtask

    // each instruction reads rs1 from d back and rs2 from d-1 back when d > 1
    task automatic dependent_chains();
        int r;
        for (int d = 1; d <= 4; d++) begin
            current_test = $sformatf("dependent distance %0d", d);
            for (int i = 0; i < 10; i++) begin
                r = 8 + i % d;
                issue(encode_r(r_ops[i][9:3], r_ops[i][2:0], r, r, 8 + (i + 1) % d));
            end
            drain();
        end
    endtask

    task automatic register_zero();
        current_test = "register zero";
        issue(encode_i(123, 3'd0, 0, 5));
        issue(encode_r(7'h00, 3'd0, 13, 0, 0));
        issue(encode_r(7'h00, 3'd6, 14, 0, 6));
        drain();
    endtask

    task automatic illegal_words();
        current_test = "illegal words";
        issue(32'h0000_2783);
        issue(encode_r(7'h01, 3'd0, 15, 3, 2));
        issue(encode_i(12'h200 | 3, 3'd1, 15, 3));
        issue(encode_i(12'h600 | 1, 3'd5, 15, 3));
        issue(encode_r(7'h20, 3'd2, 15, 1, 2));
        issue(32'h0000_07e3);
        // x15 must still hold its old value on every path
        issue(encode_r(7'h00, 3'd0, 16, 15, 0));
        drain();
    endtask

    task automatic random_stream();
        current_test = "random stream";
        for (int n = 0; n < 200; n++) begin
            if ($urandom_range(3) == 0) issue($urandom);
            else issue(random_legal());
            idle($urandom_range(2));
        end
        drain();
    endtask

    // the monitor compares every retirement with the oldest outstanding prediction
    always @(negedge clock) begin
        if (reset) begin
            assert (retire.valid === 1'b0) else begin
                other_errors++;
                $display("retire.valid was high during reset");
            end
        end else if (retire.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("%s: an instruction retired with none outstanding", current_test);
            end else begin
                head = exp_q.pop_front();
                head_edge = accept_q.pop_front();
                assert (retire === head) else begin
                    value_errors++;
                    $display("ERR %s expected %h actual %h", current_test, head, retire);
                end
                assert (edge_count - head_edge == 3) else begin
                    timing_errors++;
                    $display("%s: retired %0d cycles after acceptance instead of 3",
                             current_test, edge_count - head_edge);
                end
            end
        end
    end

    initial begin
        void'($urandom(64625));
        reset = 1'b1;
        instr_valid = 1'b0;
        instr_word = '0;
        foreach (model[i]) model[i] = '0;
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;
        // the monitor flags any stray retirement in these idle cycles after reset
        idle(8);
        load_registers();
        immediate_forms();
        dependent_chains();
        register_zero();
        illegal_words();
        random_stream();
        $display("errors: value %0d, timing %0d, other %0d",
                 value_errors, timing_errors, other_errors);
        if (value_errors + timing_errors + other_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: all.f
logic/rv_pkg.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_result.sv
logic/rv_core.sv
bench/rv_core_tb.sv

// File: Makefile
# Verilator build and run of the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= rv_core_tb
RTL_TOP   ?= rv_core
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= tests failed
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall
RTL_SRCS  ?= logic/rv_pkg.sv logic/rv_decode.sv logic/rv_execute.sv \
             logic/rv_result.sv logic/rv_core.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: build
	@./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
